/* hdl/debugLink_settings.svh */
`ifndef DEBUG_LINK_SETTINGS_SVH
`define DEBUG_LINK_SETTINGS_SVH

// Message framing
`define MSG_MAX_PAYLOAD 5
`define MSG_HEADER_LEN 2

// Queue address widths, four entries each
`define INQ_DEPTH_LOG2 2
`define OUTQ_DEPTH_LOG2 2

// Message type codes
`define MSG_TYPE_SET_LED 8'h01
`define MSG_TYPE_PING 8'h02
`define MSG_REPLY_FLAG 8'h80

`endif

/* hdl/debugLinkPkg.sv */
`include "debugLink_settings.svh"

package debugLinkPkg;

    typedef logic [7:0] byteT;
    typedef logic [7:0] msgTypeT;
    typedef logic [7:0] payloadLenT;
    typedef logic [3:0] ledT;

    // Byte 0 sits in the lowest bits
    typedef byteT [`MSG_MAX_PAYLOAD-1:0] payloadT;

    // In-queue word and sender input, 56 bits
    typedef struct packed {
        msgTypeT    msgType;
        payloadLenT len;
        payloadT    payload;
    } msgT;

    typedef enum logic [1:0] {RxIdle, RxType, RxLength, RxPayload} rxStateT;
    typedef enum logic {TxLoad, TxShift} txStateT;
    typedef enum logic [1:0] {SendIdle, SendHeader, SendPayload, SendDrain} sendStateT;
    typedef enum logic [1:0] {CmdWait, CmdExecute, CmdReply} cmdStateT;

    // Number of payload bytes that are actually stored for a given length
    function automatic payloadLenT clampLen(payloadLenT len);
        return (len > `MSG_MAX_PAYLOAD) ? payloadLenT'(`MSG_MAX_PAYLOAD) : len;
    endfunction

endpackage

/* hdl/asyncFifo.sv */
`timescale 1ns/1ps

module asyncFifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             wclk,
    input  logic             wrstN,
    input  logic             write,
    input  logic [WIDTH-1:0] wdata,
    output logic             writeOk,
    input  logic             rclk,
    input  logic             rrstN,
    input  logic             read,
    output logic [WIDTH-1:0] rdata,
    output logic             readOk
);
    // One extra pointer bit tells full from empty
    localparam int PTR_W = DEPTH_LOG2 + 1;

    logic [WIDTH-1:0] mem [2**DEPTH_LOG2];
    logic [PTR_W-1:0] wBin;
    logic [PTR_W-1:0] wBinNext;
    logic [PTR_W-1:0] wGray;
    logic [PTR_W-1:0] rBin;
    logic [PTR_W-1:0] rBinNext;
    logic [PTR_W-1:0] rGray;
    logic [PTR_W-1:0] rGraySync1;
    logic [PTR_W-1:0] rGraySync2;
    logic [PTR_W-1:0] wGraySync1;
    logic [PTR_W-1:0] wGraySync2;

    // ========================================
    // Write side
    // ========================================
    assign wBinNext = wBin + 1'b1;
    // Full when the read pointer is one lap behind
    assign writeOk = (wGray != {~rGraySync2[PTR_W-1 -: 2], rGraySync2[PTR_W-3:0]});

    always_ff @(posedge wclk or negedge wrstN) begin
        if (!wrstN) begin
            wBin <= '0;
            wGray <= '0;
            rGraySync1 <= '0;
            rGraySync2 <= '0;
        end else begin
            rGraySync1 <= rGray;
            rGraySync2 <= rGraySync1;
            if (write && writeOk) begin
                wBin <= wBinNext;
                wGray <= wBinNext ^ (wBinNext >> 1);
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (write && writeOk) begin
            mem[wBin[DEPTH_LOG2-1:0]] <= wdata;
        end
    end

    // ========================================
    // Read side
    // ========================================
    assign rBinNext = rBin + 1'b1;
    assign readOk = (rGray != wGraySync2);
    assign rdata = mem[rBin[DEPTH_LOG2-1:0]];

    always_ff @(posedge rclk or negedge rrstN) begin
        if (!rrstN) begin
            rBin <= '0;
            rGray <= '0;
            wGraySync1 <= '0;
            wGraySync2 <= '0;
        end else begin
            wGraySync1 <= wGray;
            wGraySync2 <= wGraySync1;
            if (read && readOk) begin
                rBin <= rBinNext;
                rGray <= rBinNext ^ (rBinNext >> 1);
            end
        end
    end

endmodule

/* hdl/serialRx.sv */
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module serialRx
    import debugLinkPkg::*;
(
    input  logic debugClk,
    input  logic rstN,
    input  logic debugCs,
    input  logic debugDi,
    output logic inqWrite,
    output msgT  inqMsg
);
    // Bit 8 is a sentinel that reaches the top once eight data bits are in
    logic [8:0] shiftReg;
    logic       byteReady;
    byteT       rxByte;
    rxStateT    state;
    payloadLenT rxCount;
    logic       storeType;
    logic       storeLen;
    logic       storeData;

    assign byteReady = shiftReg[8];
    assign rxByte = shiftReg[7:0];

    // Zero type bytes are idle filler and never open a message
    assign storeType = debugCs && byteReady && (state == RxType) && (rxByte != '0);
    assign storeLen = debugCs && byteReady && (state == RxLength);
    assign storeData = debugCs && byteReady && (state == RxPayload);

    always_ff @(posedge debugClk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= '0;
            state <= RxIdle;
            rxCount <= '0;
            inqWrite <= 1'b0;
        end else if (!debugCs) begin
            shiftReg <= '0;
            state <= RxIdle;
            rxCount <= '0;
            inqWrite <= 1'b0;
        end else begin
            inqWrite <= 1'b0;
            shiftReg <= byteReady ? {7'd0, 1'b1, debugDi} : {shiftReg[7:0], debugDi};
            case (state)
                RxIdle: begin
                    // First edge after select starts byte zero
                    shiftReg <= {7'd0, 1'b1, debugDi};
                    state <= RxType;
                end
                RxType: begin
                    if (storeType) begin
                        state <= RxLength;
                    end
                end
                RxLength: begin
                    if (storeLen) begin
                        rxCount <= '0;
                        if (rxByte == '0) begin
                            inqWrite <= 1'b1;
                            state <= RxType;
                        end else begin
                            state <= RxPayload;
                        end
                    end
                end
                RxPayload: begin
                    if (storeData) begin
                        rxCount <= rxCount + 8'd1;
                        if (rxCount + 8'd1 == inqMsg.len) begin
                            inqWrite <= 1'b1;
                            state <= RxType;
                        end
                    end
                end
                default: state <= RxIdle;
            endcase
        end
    end

    // Bytes past the stored maximum are counted but dropped
    always_ff @(posedge debugClk) begin
        if (storeType) begin
            inqMsg.msgType <= rxByte;
            inqMsg.payload <= '0;
        end
        if (storeLen) begin
            inqMsg.len <= rxByte;
        end
        if (storeData && (rxCount < `MSG_MAX_PAYLOAD)) begin
            inqMsg.payload[rxCount] <= rxByte;
        end
    end

endmodule

/* hdl/serialTx.sv */
`timescale 1ns/1ps

module serialTx
    import debugLinkPkg::*;
(
    input  logic debugClk,
    input  logic rstN,
    input  logic debugCs,
    input  byteT outqByte,
    input  logic outqReadOk,
    output logic outqRead,
    output logic debugDo
);
    // Sentinel placed so that the next edge requests a byte
    localparam logic [8:0] ARMED = 9'b0_0100_0000;

    // Low bit holds the sentinel, which walks up as data goes out
    logic [8:0] shiftReg;
    txStateT    state;

    assign debugDo = shiftReg[8];

    always_ff @(posedge debugClk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= ARMED;
            state <= TxShift;
            outqRead <= 1'b0;
        end else if (!debugCs) begin
            shiftReg <= ARMED;
            state <= TxShift;
            outqRead <= 1'b0;
        end else begin
            case (state)
                TxLoad: begin
                    // Empty queue sends an idle zero byte
                    shiftReg <= {(outqReadOk ? outqByte : 8'h00), 1'b1};
                    outqRead <= 1'b0;
                    state <= TxShift;
                end
                TxShift: begin
                    shiftReg <= shiftReg << 1;
                    if (shiftReg[6:0] == 7'b100_0000) begin
                        outqRead <= 1'b1;
                        state <= TxLoad;
                    end
                end
                default: state <= TxShift;
            endcase
        end
    end

endmodule

/* hdl/msgSender.sv */
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module msgSender
    import debugLinkPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  msgT  reply,
    input  logic replySend,
    input  logic outqWriteOk,
    output logic senderBusy,
    output logic outqWrite,
    output byteT outqByte
);
    sendStateT  state;
    msgT        msg;
    logic [2:0] byteIdx;

    assign senderBusy = (state != SendIdle);
    // Hold the current byte while the out queue is full
    assign outqWrite = outqWriteOk && ((state == SendHeader) || (state == SendPayload));

    always_comb begin
        outqByte = '0;
        case (state)
            SendHeader: outqByte = (byteIdx == '0) ? msg.msgType : msg.len;
            SendPayload: outqByte = msg.payload[byteIdx];
            default: outqByte = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= SendIdle;
            byteIdx <= '0;
        end else begin
            case (state)
                SendIdle: begin
                    if (replySend) begin
                        byteIdx <= '0;
                        state <= SendHeader;
                    end
                end
                SendHeader: begin
                    if (outqWrite) begin
                        if (byteIdx == `MSG_HEADER_LEN - 1) begin
                            byteIdx <= '0;
                            state <= (msg.len == '0) ? SendDrain : SendPayload;
                        end else begin
                            byteIdx <= byteIdx + 3'd1;
                        end
                    end
                end
                SendPayload: begin
                    if (outqWrite) begin
                        byteIdx <= byteIdx + 3'd1;
                        if (byteIdx == msg.len - 1) begin
                            state <= SendDrain;
                        end
                    end
                end
                // One settle cycle after the final write
                SendDrain: state <= SendIdle;
                default: state <= SendIdle;
            endcase
        end
    end

    // Length is clamped here so only stored bytes are sent
    always_ff @(posedge clk) begin
        if ((state == SendIdle) && replySend) begin
            msg.msgType <= reply.msgType;
            msg.len <= clampLen(reply.len);
            msg.payload <= reply.payload;
        end
    end

endmodule

/* hdl/cmdHandler.sv */
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module cmdHandler
    import debugLinkPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  msgT  inqMsg,
    input  logic inqReadOk,
    input  logic senderBusy,
    output logic inqRead,
    output logic replySend,
    output ledT  led,
    output msgT  reply
);
    cmdStateT state;
    logic     isSetLed;
    logic     isPing;

    assign isSetLed = (inqMsg.msgType == `MSG_TYPE_SET_LED);
    assign isPing = (inqMsg.msgType == `MSG_TYPE_PING);

    // Head entry is decoded and popped in the same cycle
    assign inqRead = (state == CmdExecute);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= CmdWait;
            led <= '0;
            replySend <= 1'b0;
        end else begin
            replySend <= 1'b0;
            case (state)
                CmdWait: begin
                    if (inqReadOk) begin
                        state <= CmdExecute;
                    end
                end
                CmdExecute: begin
                    if (isSetLed) begin
                        led <= inqMsg.payload[0][3:0];
                    end
                    // Unknown types are consumed silently
                    state <= (isSetLed || isPing) ? CmdReply : CmdWait;
                end
                CmdReply: begin
                    if (!senderBusy) begin
                        replySend <= 1'b1;
                        state <= CmdWait;
                    end
                end
                default: state <= CmdWait;
            endcase
        end
    end

    // Reply echoes the stored payload under the flagged type
    always_ff @(posedge clk) begin
        if (state == CmdExecute) begin
            reply.msgType <= inqMsg.msgType | `MSG_REPLY_FLAG;
            reply.len <= clampLen(inqMsg.len);
            reply.payload <= inqMsg.payload;
        end
    end

endmodule

/* hdl/debugTop.sv */
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module debugTop
    import debugLinkPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic debugClk,
    input  logic debugCs,
    input  logic debugDi,
    output logic debugDo,
    output ledT  led
);
    logic rxWrite;
    msgT  rxMsg;
    msgT  inqMsg;
    logic inqReadOk;
    logic inqRead;
    msgT  reply;
    logic replySend;
    logic senderBusy;
    logic outqWrite;
    logic outqWriteOk;
    byteT sendByte;
    byteT outqHead;
    logic outqRead;
    logic outqReadOk;

    // ========================================
    // Debug clock to system clock
    // ========================================
    serialRx rx (.debugClk(debugClk), .rstN(rstN), .debugCs(debugCs), .debugDi(debugDi),
        .inqWrite(rxWrite), .inqMsg(rxMsg));

    // A full in queue drops the incoming message
    asyncFifo #(.WIDTH($bits(msgT)), .DEPTH_LOG2(`INQ_DEPTH_LOG2)) inq (
        .wclk(debugClk), .wrstN(rstN), .write(rxWrite), .wdata(rxMsg), .writeOk(),
        .rclk(clk), .rrstN(rstN), .read(inqRead), .rdata(inqMsg), .readOk(inqReadOk));

    cmdHandler cmd (.clk(clk), .rstN(rstN), .inqMsg(inqMsg), .inqReadOk(inqReadOk),
        .senderBusy(senderBusy), .inqRead(inqRead), .replySend(replySend), .led(led),
        .reply(reply));

    // ========================================
    // System clock back to debug clock
    // ========================================
    msgSender sender (.clk(clk), .rstN(rstN), .reply(reply), .replySend(replySend),
        .outqWriteOk(outqWriteOk), .senderBusy(senderBusy), .outqWrite(outqWrite),
        .outqByte(sendByte));

    asyncFifo #(.WIDTH($bits(byteT)), .DEPTH_LOG2(`OUTQ_DEPTH_LOG2)) outq (
        .wclk(clk), .wrstN(rstN), .write(outqWrite), .wdata(sendByte), .writeOk(outqWriteOk),
        .rclk(debugClk), .rrstN(rstN), .read(outqRead), .rdata(outqHead), .readOk(outqReadOk));

    serialTx tx (.debugClk(debugClk), .rstN(rstN), .debugCs(debugCs), .outqByte(outqHead),
        .outqReadOk(outqReadOk), .outqRead(outqRead), .debugDo(debugDo));

endmodule

/* test/debugTop_assertions.sv */
`timescale 1ns/1ps

module debugTop_assertions
    import debugLinkPkg::*;
(
    input logic clk,
    input logic rstN,
    input logic replySend,
    input logic senderBusy,
    input logic outqWriteOk,
    input byteT sendByte,
    input ledT  led
);
    // Count of failed assertions
    int errorCount = 0;

    // Sender takes a new reply only when idle
    replyWhileIdle: assert property (@(posedge clk) disable iff (!rstN)
        replySend |-> !senderBusy)
        else begin
            $error("replySend raised while the sender is busy");
            errorCount++;
        end

    // Full out queue holds the pending byte in place
    byteHeldWhileFull: assert property (@(posedge clk) disable iff (!rstN)
        (senderBusy && !outqWriteOk) |=> $stable(sendByte))
        else begin
            $error("sendByte changed while the out queue is full");
            errorCount++;
        end

    ledClearInReset: assert property (@(posedge clk) !rstN |-> (led == '0))
        else begin
            $error("led is not zero during reset");
            errorCount++;
        end

endmodule

bind debugTop debugTop_assertions debugTopChecks (.clk(clk), .rstN(rstN),
    .replySend(replySend), .senderBusy(senderBusy), .outqWriteOk(outqWriteOk),
    .sendByte(sendByte), .led(led));

/* test/debugTop_tb.sv */
`timescale 1ns/1ps
`include "debugLink_settings.svh"

module debugTop_tb
    import debugLinkPkg::*;
();
    localparam int NUM_ENTRIES = 16;
    localparam int CYCLES_PER_ENTRY = 400;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * CYCLES_PER_ENTRY;

    // Payload bytes past a fixed first byte come from the LCG
    typedef struct packed {
        msgTypeT    msgType;
        payloadLenT len;
        byteT       firstByte;
        logic       randomPayload;
        ledT        expLed;
        logic       expReply;
        logic       waitDone;
    } stimT;

    logic clk;
    logic rstN;
    logic debugClk;
    logic debugCs;
    logic debugDi;
    logic debugDo;
    ledT  led;

    stimT        stimTable [NUM_ENTRIES];
    byteT        sendQ [$];
    msgT         expQ [$];
    msgT         gotQ [$];
    logic [31:0] lcgState = 32'h4029_bbef;
    int          cycleCount = 0;

    debugTop debugTop_inst (.clk(clk), .rstN(rstN), .debugClk(debugClk), .debugCs(debugCs),
        .debugDi(debugDi), .debugDo(debugDo), .led(led));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        debugClk = 1'b0;
        forever #13 debugClk = ~debugClk;
    end

    // ========================================
    // Helpers and compare tasks
    // ========================================
    function automatic byteT randomByte();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[23:16];
    endfunction

    task automatic abortRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkLed(ledT got, ledT expVal);
        if (got !== expVal) begin
            $display("** Error: led got 0x%h, expected 0x%h", got, expVal);
            abortRun();
        end
    endtask

    task automatic checkType(string name, msgTypeT got, msgTypeT expVal);
        if (got !== expVal) begin
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, expVal);
            abortRun();
        end
    endtask

    task automatic checkByte(string name, byteT got, byteT expVal);
        if (got !== expVal) begin
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, expVal);
            abortRun();
        end
    endtask

    // Idle gap, then the framed message; the reply follows the flag and clamp rule
    task automatic queueMessage(stimT entry);
        byteT data;
        msgT  expMsg;
        expMsg = '0;
        expMsg.msgType = entry.msgType | `MSG_REPLY_FLAG;
        expMsg.len = (entry.len > `MSG_MAX_PAYLOAD) ? payloadLenT'(`MSG_MAX_PAYLOAD) : entry.len;
        data = randomByte();
        if (data[0]) begin
            sendQ.push_back(8'h00);
        end
        if (data[1]) begin
            sendQ.push_back(8'h00);
        end
        sendQ.push_back(entry.msgType);
        sendQ.push_back(entry.len);
        for (int i = 0; i < entry.len; i++) begin
            data = (i == 0 && !entry.randomPayload) ? entry.firstByte : randomByte();
            sendQ.push_back(data);
            if (i < `MSG_MAX_PAYLOAD) begin
                expMsg.payload[i] = data;
            end
        end
        if (entry.expReply) begin
            expQ.push_back(expMsg);
        end
    endtask

    task automatic compareReplies();
        msgT gotMsg;
        msgT expMsg;
        while (expQ.size() > 0) begin
            gotMsg = gotQ.pop_front();
            expMsg = expQ.pop_front();
            checkType("reply type", gotMsg.msgType, expMsg.msgType);
            checkByte("reply length", gotMsg.len, expMsg.len);
            for (int i = 0; i < expMsg.len; i++) begin
                checkByte("reply payload", gotMsg.payload[i], expMsg.payload[i]);
            end
        end
        if (gotQ.size() > 0) begin
            gotMsg = gotQ[0];
            $display("A reply of type 0x%h arrived where none was expected", gotMsg.msgType);
            abortRun();
        end
    endtask

    // ========================================
    // Serial driver and monitor
    // ========================================
    initial begin : serialDriver
        byteT data;
        wait (rstN === 1'b1);
        @(posedge debugClk);
        #1;
        debugCs = 1'b1;
        // Zero bytes fill the line while nothing is queued
        forever begin
            data = (sendQ.size() > 0) ? sendQ.pop_front() : 8'h00;
            for (int i = 7; i >= 0; i--) begin
                debugDi = data[i];
                @(posedge debugClk);
                #1;
            end
        end
    end

    initial begin : serialMonitor
        byteT data;
        msgT  cur;
        int   idx;
        int   phase;
        phase = 0;
        idx = 0;
        cur = '0;
        wait (debugCs === 1'b1);
        // Skip edge zero since bit k shows after edge k+1
        @(posedge debugClk);
        forever begin
            for (int i = 0; i < 8; i++) begin
                @(posedge debugClk);
                @(negedge debugClk);
                data = {data[6:0], debugDo};
            end
            case (phase)
                0: begin
                    if (data != 8'h00) begin
                        cur = '0;
                        cur.msgType = data;
                        phase = 1;
                    end
                end
                1: begin
                    cur.len = data;
                    idx = 0;
                    if (data == 8'h00) begin
                        gotQ.push_back(cur);
                        phase = 0;
                    end else begin
                        phase = 2;
                    end
                end
                default: begin
                    if (idx < `MSG_MAX_PAYLOAD) begin
                        cur.payload[idx] = data;
                    end
                    idx++;
                    if (idx == cur.len) begin
                        gotQ.push_back(cur);
                        phase = 0;
                    end
                end
            endcase
        end
    end

    initial begin : timeoutWatch
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d clk cycles, no reply arrived", cycleCount);
                abortRun();
            end
        end
    end

    initial begin : assertionWatch
        wait (debugTop_inst.debugTopChecks.errorCount != 0);
        $display("A bound assertion on the DUT failed");
        abortRun();
    end

    // ========================================
    // Stimulus table and main sequence
    // ========================================
    initial begin
        rstN = 1'b0;
        debugCs = 1'b0;
        debugDi = 1'b0;
        // type, len, first byte, random payload, led, reply, wait
        stimTable = '{
            '{8'h01, 8'd1, 8'hA5, 1'b0, 4'h5, 1'b1, 1'b1},
            '{8'h01, 8'd1, 8'h3C, 1'b0, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd0, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd1, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd2, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd3, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd4, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd5, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h02, 8'd7, 8'h00, 1'b1, 4'hC, 1'b1, 1'b1},
            '{8'h01, 8'd1, 8'h07, 1'b0, 4'h7, 1'b1, 1'b1},
            '{8'h33, 8'd2, 8'h00, 1'b1, 4'h7, 1'b0, 1'b0},
            '{8'h02, 8'd2, 8'h00, 1'b1, 4'h7, 1'b1, 1'b1},
            '{8'h01, 8'd1, 8'h19, 1'b0, 4'h9, 1'b1, 1'b1},
            '{8'h02, 8'd5, 8'h00, 1'b1, 4'h9, 1'b1, 1'b0},
            '{8'h02, 8'd5, 8'h00, 1'b1, 4'h9, 1'b1, 1'b0},
            '{8'h02, 8'd5, 8'h00, 1'b1, 4'h9, 1'b1, 1'b1}
        };
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkLed(led, 4'h0);
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            queueMessage(stimTable[n]);
            // Rows without wait stack up back to back
            if (stimTable[n].waitDone) begin
                while ((gotQ.size() < expQ.size()) || (sendQ.size() > 0)) begin
                    @(negedge clk);
                end
                compareReplies();
                checkLed(led, stimTable[n].expLed);
            end
        end
        if (debugTop_inst.debugTopChecks.errorCount == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abortRun();
        end
    end

endmodule

/* debugLink.f */
+incdir+hdl
hdl/debugLinkPkg.sv
hdl/asyncFifo.sv
hdl/serialRx.sv
hdl/serialTx.sv
hdl/msgSender.sv
hdl/cmdHandler.sv
hdl/debugTop.sv
test/debugTop_assertions.sv
test/debugTop_tb.sv

/* Bender.yml */
package:
  name: debugLink

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/debugLinkPkg.sv
      - hdl/asyncFifo.sv
      - hdl/serialRx.sv
      - hdl/serialTx.sv
      - hdl/msgSender.sv
      - hdl/cmdHandler.sv
      - hdl/debugTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/debugTop_assertions.sv
      - test/debugTop_tb.sv
